//--- logic/fetch_pkg.sv
////////////////////
// Shared types and constants of the fetch front end
// Bus is Wishbone classic, 32-bit, word addressed by byte address
////////////////////
package fetch_pkg;

  ////////////////////
  // Constants
  ////////////////////

  // Words held by the alignment buffer
  localparam int unsigned ALIGN_DEPTH = 3;

  // Accepted requests still waiting for a response
  localparam int unsigned MAX_OUTSTANDING = 2;

  ////////////////////
  // Wishbone bundles
  ////////////////////

  // Master-driven side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
  } wb_req_t;

  // Slave-driven side, err and rty not carried
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_rsp_t;

  // One fetched word, master to buffer
  typedef struct packed {
    logic [31:0] rdata;
  } inst_resp_t;

  // One instruction toward decode
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;
  } fetch_instr_t;

  // Master bus FSM
  typedef enum logic {
    WB_IDLE  = 1'b0,
    WB_CYCLE = 1'b1
  } wb_state_e;

endpackage

//--- logic/fetch_align_buffer.sv
`timescale 1ns/10ps
////////////////////
// Depth of three words is built into the counting logic
// Branch targets may be halfword aligned, fetch requests are word aligned
////////////////////
module fetch_align_buffer (
  input  logic                    clk,
  input  logic                    rst_n,

  // Branch control
  input  logic                    branch_i,
  input  logic [31:0]             branch_addr_i,
  input  logic                    prefetch_en_i,
  output logic                    busy_o,

  // Request side toward the bus master
  output logic                    fetch_valid_o,
  input  logic                    fetch_ready_i,
  output logic                    fetch_branch_o,
  output logic [31:0]             fetch_branch_addr_o,

  // Returned words, in request order
  input  logic                    resp_valid_i,
  input  fetch_pkg::inst_resp_t   resp_i,

  // Decode handshake
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output fetch_pkg::fetch_instr_t instr_o
);

  // Word storage, entry 0 feeds the output
  logic [fetch_pkg::ALIGN_DEPTH-1:0][31:0] rdata_q, rdata_int, rdata_n;
  logic [fetch_pkg::ALIGN_DEPTH-1:0]       valid_q, valid_int, valid_n;

  // Address of the instruction at the head
  logic [31:0] addr_q, addr_n, addr_incr;

  // Counters, instructions held and requests in flight
  logic [2:0]  instr_cnt_q, instr_cnt_n;
  logic [1:0]  outstanding_cnt_q, outstanding_cnt_n;
  logic [1:0]  n_flush_q, n_flush_n;
  logic [1:0]  n_incoming;

  // Write-side parse state of the halfword stream
  logic        aligned_q, aligned_n;
  logic        complete_q, complete_n;

  // Set by the first branch, no start address exists before it
  logic        started_q;

  logic        resp_valid_gated;
  logic        take;
  logic        count_up;
  logic        count_down;
  logic [31:0] instr_lo, instr_hi_src, instr_unaligned;
  logic        word_valid, pair_valid;
  logic        aligned_compressed, unaligned_compressed;
  logic        lo_compressed, hi_compressed;

  ////////////////////
  // Request side
  ////////////////////

  // Words belonging to a stale stream are swallowed here
  assign resp_valid_gated = (n_flush_q != 2'd0) ? 1'b0 : resp_valid_i;

  // Ask for more only when short of complete instructions
  assign fetch_valid_o = prefetch_en_i && (started_q || branch_i) &&
                         (outstanding_cnt_q < fetch_pkg::MAX_OUTSTANDING) &&
                         ((instr_cnt_q == 3'd0) ||
                          (instr_cnt_q == 3'd1 && outstanding_cnt_q == 2'd0) ||
                          branch_i);

  assign busy_o = (outstanding_cnt_q != 2'd0) || fetch_valid_o;

  // Master always fetches whole words
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[31:2], 2'b00};

  ////////////////////
  // Output assembly
  ////////////////////

  // Aligned case lives in entry 0, or in the word arriving now
  assign instr_lo     = valid_q[0] ? rdata_q[0] : resp_i.rdata;
  // Second half of a split instruction
  assign instr_hi_src = valid_q[1] ? rdata_q[1] : resp_i.rdata;
  assign instr_unaligned = {instr_hi_src[15:0], instr_lo[31:16]};

  // Entry 1 valid implies entry 0 valid
  assign word_valid = valid_q[0] || resp_valid_gated;
  assign pair_valid = valid_q[1] || (valid_q[0] && resp_valid_gated);

  assign aligned_compressed   = instr_lo[1:0] != 2'b11;
  assign unaligned_compressed = instr_lo[17:16] != 2'b11;

  always_comb begin
    instr_valid_o = 1'b0;
    if (branch_i) begin
      // Head is stale during a branch
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      // Upper half of entry 0, maybe plus the next word
      instr_valid_o = unaligned_compressed ? word_valid : pair_valid;
    end else begin
      instr_valid_o = word_valid;
    end
  end

  assign instr_o.instr = addr_q[1] ? instr_unaligned : instr_lo;
  assign instr_o.addr  = addr_q;

  assign take = instr_valid_o && instr_ready_i;

  ////////////////////
  // Storage update
  ////////////////////

  // Incoming word goes to the first free entry
  always_comb begin : store_word
    logic placed;
    placed    = 1'b0;
    rdata_int = rdata_q;
    valid_int = valid_q;
    if (resp_valid_gated) begin
      for (int j = 0; j < fetch_pkg::ALIGN_DEPTH; j++) begin
        if (!valid_q[j] && !placed) begin
          rdata_int[j] = resp_i.rdata;
          valid_int[j] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  assign addr_incr = {addr_q[31:2], 2'b00} + 32'd4;

  // Pop one word whenever the taken instruction reaches the word boundary
  always_comb begin
    addr_n  = addr_q;
    rdata_n = rdata_int;
    valid_n = valid_int;
    if (take) begin
      if (addr_q[1]) begin
        // Split 32-bit instr ends mid next word
        addr_n = {addr_incr[31:2], (unaligned_compressed ? 2'b00 : 2'b10)};
      end else if (aligned_compressed) begin
        addr_n = {addr_q[31:2], 2'b10};
      end else begin
        addr_n = addr_incr;
      end
      if (addr_q[1] || !aligned_compressed) begin
        for (int i = 0; i < fetch_pkg::ALIGN_DEPTH - 1; i++) begin
          rdata_n[i] = rdata_int[i+1];
          valid_n[i] = valid_int[i+1];
        end
        valid_n[fetch_pkg::ALIGN_DEPTH-1] = 1'b0;
      end
    end
  end

  ////////////////////
  // Instruction counting
  ////////////////////

  assign lo_compressed = resp_i.rdata[1:0] != 2'b11;
  assign hi_compressed = resp_i.rdata[17:16] != 2'b11;

  // Complete instructions finished by the incoming word
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      // Halfword target means the low half of the first word is skipped
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_valid_gated) begin
      if (aligned_q) begin
        if (!lo_compressed) begin
          n_incoming = 2'd1;
        end else if (hi_compressed) begin
          n_incoming = 2'd2;
        end else begin
          // Upper half starts a 32-bit instr
          n_incoming = 2'd1;
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end
      end else begin
        // Low half either tail of a split instr or skipped after a branch
        n_incoming = {1'b0, !complete_q} + {1'b0, hi_compressed};
        aligned_n  = hi_compressed;
        complete_n = hi_compressed;
      end
    end
  end

  always_comb begin
    if (branch_i) begin
      instr_cnt_n = 3'd0;
    end else begin
      instr_cnt_n = instr_cnt_q + {1'b0, n_incoming} - {2'b00, take};
    end
  end

  assign count_up   = fetch_valid_o && fetch_ready_i;
  assign count_down = resp_valid_i;

  always_comb begin
    outstanding_cnt_n = outstanding_cnt_q + {1'b0, count_up} - {1'b0, count_down};
  end

  // Old-stream responses still to come after a branch
  always_comb begin
    n_flush_n = n_flush_q;
    if (branch_i) begin
      n_flush_n = outstanding_cnt_q - {1'b0, resp_valid_i};
    end else if (resp_valid_i && (n_flush_q != 2'd0)) begin
      n_flush_n = n_flush_q - 2'd1;
    end
  end

  ////////////////////
  // Registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q            <= '0;
      valid_q           <= '0;
      started_q         <= 1'b0;
      aligned_q         <= 1'b0;
      complete_q        <= 1'b0;
      n_flush_q         <= 2'd0;
      instr_cnt_q       <= 3'd0;
      outstanding_cnt_q <= 2'd0;
    end else begin
      if (branch_i) begin
        // Drop all held words, head restarts at the target
        valid_q   <= '0;
        addr_q    <= branch_addr_i;
        started_q <= 1'b1;
      end else begin
        valid_q <= valid_n;
        addr_q  <= addr_n;
      end
      aligned_q         <= aligned_n;
      complete_q        <= complete_n;
      n_flush_q         <= n_flush_n;
      instr_cnt_q       <= instr_cnt_n;
      outstanding_cnt_q <= outstanding_cnt_n;
    end
  end

  // Word payload, qualified by valid_q
  always_ff @(posedge clk) begin
    rdata_q <= rdata_n;
  end

  ////////////////////
  // Checks
  ////////////////////

  a_outstanding_max: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_cnt_q <= fetch_pkg::MAX_OUTSTANDING)
    else $error("outstanding count above limit");

  a_no_valid_on_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_i |-> !instr_valid_o)
    else $error("instruction offered during branch");

  // Request throttling must leave room for every live response
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_gated |-> !(&valid_q))
    else $error("response arrived with buffer full");

endmodule

//--- logic/fetch_wb_master.sv
`timescale 1ns/10ps
////////////////////
// One Wishbone classic read at a time, one more request parked in a slot
// Bus errors are not handled, ack is the only response
////////////////////
module fetch_wb_master (
  input  logic                  clk,
  input  logic                  rst_n,

  // Requests from the alignment buffer
  input  logic                  fetch_valid_i,
  output logic                  fetch_ready_o,
  input  logic                  fetch_branch_i,
  input  logic [31:0]           fetch_branch_addr_i,

  // Returned words
  output logic                  resp_valid_o,
  output fetch_pkg::inst_resp_t resp_o,

  // Wishbone
  output fetch_pkg::wb_req_t    wb_req_o,
  input  fetch_pkg::wb_rsp_t    wb_rsp_i
);

  fetch_pkg::wb_state_e state_q, state_n;

  logic        slot_valid_q, slot_valid_n;
  logic [31:0] slot_addr_q, slot_addr_n;
  logic [31:0] fetch_addr_q, fetch_addr_n;
  logic [31:0] adr_q, adr_n;
  logic [31:0] req_addr;
  logic        accept;
  logic        bus_done;
  logic        bus_free;

  assign fetch_ready_o = !slot_valid_q;
  assign accept        = fetch_valid_i && fetch_ready_o;

  // Branch target overrides the running address
  assign req_addr = fetch_branch_i ? fetch_branch_addr_i : fetch_addr_q;

  assign bus_done = (state_q == fetch_pkg::WB_CYCLE) && wb_rsp_i.ack;
  assign bus_free = (state_q == fetch_pkg::WB_IDLE) || bus_done;

  always_comb begin
    state_n      = state_q;
    slot_valid_n = slot_valid_q;
    slot_addr_n  = slot_addr_q;
    adr_n        = adr_q;
    fetch_addr_n = fetch_addr_q;

    if (accept) begin
      fetch_addr_n = req_addr + 32'd4;
    end else if (fetch_branch_i) begin
      // Keep the target for a later request
      fetch_addr_n = fetch_branch_addr_i;
    end

    if (bus_free) begin
      if (slot_valid_q) begin
        // Parked request goes first
        state_n      = fetch_pkg::WB_CYCLE;
        adr_n        = slot_addr_q;
        slot_valid_n = 1'b0;
      end else if (accept) begin
        // Bypass the slot, cycle starts next clock
        state_n = fetch_pkg::WB_CYCLE;
        adr_n   = req_addr;
      end else begin
        state_n = fetch_pkg::WB_IDLE;
      end
    end else if (accept) begin
      slot_valid_n = 1'b1;
      slot_addr_n  = req_addr;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= fetch_pkg::WB_IDLE;
      slot_valid_q <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      state_q      <= state_n;
      slot_valid_q <= slot_valid_n;
      fetch_addr_q <= fetch_addr_n;
    end
  end

  // Addresses only matter under cyc or slot_valid_q
  always_ff @(posedge clk) begin
    slot_addr_q <= slot_addr_n;
    adr_q       <= adr_n;
  end

  // Read only, full word
  assign wb_req_o.cyc = (state_q == fetch_pkg::WB_CYCLE);
  assign wb_req_o.stb = (state_q == fetch_pkg::WB_CYCLE);
  assign wb_req_o.we  = 1'b0;
  assign wb_req_o.sel = 4'hf;
  assign wb_req_o.adr = adr_q;

  assign resp_valid_o = bus_done;
  assign resp_o.rdata = wb_rsp_i.dat;

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_req_o.stb |-> wb_req_o.cyc)
    else $error("stb without cyc");

  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_req_o.stb && !wb_rsp_i.ack) |=> $stable(wb_req_o.adr))
    else $error("adr changed before ack");

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/10ps
////////////////////
// Idle until the first branch gives a start address
////////////////////
module fetch_unit (
  input  logic                    clk,
  input  logic                    rst_n,

  // Branch control
  input  logic                    branch_i,
  input  logic [31:0]             branch_addr_i,
  input  logic                    prefetch_en_i,
  output logic                    busy_o,

  // Decode handshake
  output logic                    instr_valid_o,
  input  logic                    instr_ready_i,
  output fetch_pkg::fetch_instr_t instr_o,

  // Wishbone
  output fetch_pkg::wb_req_t      wb_req_o,
  input  fetch_pkg::wb_rsp_t      wb_rsp_i
);

  // Buffer to master request path
  logic                  fetch_valid;
  logic                  fetch_ready;
  logic                  fetch_branch;
  logic [31:0]           fetch_branch_addr;

  // Master to buffer response path
  logic                  resp_valid;
  fetch_pkg::inst_resp_t resp;

  fetch_align_buffer u_align_buffer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .prefetch_en_i       (prefetch_en_i),
    .busy_o              (busy_o),
    .fetch_valid_o       (fetch_valid),
    .fetch_ready_i       (fetch_ready),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .resp_valid_i        (resp_valid),
    .resp_i              (resp),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_o             (instr_o)
  );

  fetch_wb_master u_wb_master (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_valid_i       (fetch_valid),
    .fetch_ready_o       (fetch_ready),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .resp_valid_o        (resp_valid),
    .resp_o              (resp),
    .wb_req_o            (wb_req_o),
    .wb_rsp_i            (wb_rsp_i)
  );

endmodule

//--- tb/tb_imem_model.sv
`timescale 1ns/10ps
////////////////////
// Read-only Wishbone classic memory of 256 words, address wraps at 1 KB
// Ack is combinational after 0 to 3 wait states, write cycles are not modeled
////////////////////
module tb_imem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  fetch_pkg::wb_req_t wb_req_i,
  output fetch_pkg::wb_rsp_t wb_rsp_o
);

  // Word image, loaded by the testbench through the hierarchy
  logic [31:0] mem [0:255];

  // Wait states drawn for the current cycle, and those already spent
  logic [1:0]  wait_q;
  logic [1:0]  cnt_q;
  logic        req;

  assign req = wb_req_i.cyc && wb_req_i.stb;

  // Ack ends the cycle once the wait states are used up
  assign wb_rsp_o.ack = req && (cnt_q == wait_q);
  assign wb_rsp_o.dat = mem[wb_req_i.adr[9:2]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= 2'd0;
      wait_q <= 2'd0;
    end else if (wb_rsp_o.ack) begin
      // A back-to-back cycle starts counting from zero again
      cnt_q  <= 2'd0;
      wait_q <= 2'($urandom_range(3, 0));
    end else if (req) begin
      cnt_q <= cnt_q + 2'd1;
    end
  end

endmodule

//--- tb/tb_fetch_unit.sv
`timescale 1ns/10ps
////////////////////
// Directed tests of the fetch front end against a halfword walker
// Stimulus changes on the falling edge, results sampled at the rising edge
////////////////////
module tb_fetch_unit;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    branch_i;
  logic [31:0]             branch_addr_i;
  logic                    prefetch_en_i;
  logic                    busy_o;
  logic                    instr_valid_o;
  logic                    instr_ready_i;
  fetch_pkg::fetch_instr_t instr_o;
  fetch_pkg::wb_req_t      wb_req;
  fetch_pkg::wb_rsp_t      wb_rsp;

  // Walker position and result counters
  logic [31:0] walk_addr;
  int          check_count;
  int          mismatch_count;
  int          timeout_count;
  int          limit_cycles = 200;

  always #4 clk = ~clk;

  fetch_unit UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .prefetch_en_i (prefetch_en_i),
    .busy_o        (busy_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .wb_req_o      (wb_req),
    .wb_rsp_i      (wb_rsp)
  );

  tb_imem_model u_imem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  ////////////////////
  // Checking helpers
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout while waiting for %s at %0t", what, $time);
  endtask

  function automatic logic [15:0] halfword_at(input logic [31:0] addr);
    logic [31:0] word;
    word = u_imem.mem[addr[9:2]];
    return addr[1] ? word[31:16] : word[15:0];
  endfunction

  // Next expected instruction from the image, low bits 11 mean 32 bits long
  task automatic walk_next(output logic [31:0] exp_addr, output logic [31:0] exp_instr,
                           output logic [31:0] exp_mask);
    logic [15:0] lo;
    lo       = halfword_at(walk_addr);
    exp_addr = walk_addr;
    if (lo[1:0] != 2'b11) begin
      exp_instr = {16'h0000, lo};
      exp_mask  = 32'h0000_ffff;
      walk_addr = walk_addr + 32'd2;
    end else begin
      exp_instr = {halfword_at(walk_addr + 32'd2), lo};
      exp_mask  = 32'hffff_ffff;
      walk_addr = walk_addr + 32'd4;
    end
  endtask

  // Compare one taken instruction with the walker
  task automatic check_delivered();
    logic [31:0] exp_addr;
    logic [31:0] exp_instr;
    logic [31:0] exp_mask;
    walk_next(exp_addr, exp_instr, exp_mask);
    check_value("instr_o.addr", instr_o.addr, exp_addr);
    check_value("instr_o.instr", instr_o.instr & exp_mask, exp_instr);
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Every word starts a 32-bit instruction
  task automatic load_wide_image();
    for (int i = 0; i < 256; i++) begin
      u_imem.mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0], i[5:0], 2'b11};
    end
  endtask

  // Random halfwords give a mix of compressed and split 32-bit instructions
  task automatic load_mixed_image();
    for (int i = 0; i < 256; i++) begin
      u_imem.mem[i] = $urandom() ^ {24'h0, i[7:0]};
    end
  endtask

  // One-clock branch, also enables prefetch
  task automatic do_branch(input logic [31:0] target);
    @(negedge clk);
    prefetch_en_i = 1'b1;
    branch_i      = 1'b1;
    branch_addr_i = target;
    @(posedge clk);
    check_value("instr_valid_o", instr_valid_o, 32'd0);
    @(negedge clk);
    branch_i  = 1'b0;
    walk_addr = target;
  endtask

  // Take count instructions, ready optionally random
  task automatic collect_stream(input int count, input bit random_ready);
    int got;
    int waited;
    got    = 0;
    waited = 0;
    while (got < count && waited < limit_cycles) begin
      @(negedge clk);
      instr_ready_i = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      @(posedge clk);
      if (wb_req.cyc) begin
        check_value("wb_req_o.we", wb_req.we, 32'd0);
        check_value("wb_req_o.sel", wb_req.sel, 32'hf);
      end
      if (instr_valid_o && instr_ready_i) begin
        check_delivered();
        got++;
        waited = 0;
      end else begin
        waited++;
      end
    end
    if (got < count) begin
      report_timeout("instruction delivery");
    end
    @(negedge clk);
    instr_ready_i = 1'b0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  // Prefetch enabled, still nothing may start before a branch
  task automatic test_idle_after_reset();
    prefetch_en_i = 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      check_value("wb_req_o.cyc", wb_req.cyc, 32'd0);
      check_value("instr_valid_o", instr_valid_o, 32'd0);
      check_value("busy_o", busy_o, 32'd0);
    end
  endtask

  task automatic test_aligned_wide();
    load_wide_image();
    do_branch(32'h0000_0100);
    collect_stream(16, 1'b0);
  endtask

  task automatic test_mixed_aligned();
    load_mixed_image();
    do_branch(32'h0000_0040);
    collect_stream(32, 1'b0);
  endtask

  // Compressed at 0x52, then a 32-bit instruction at 0xa2
  task automatic test_halfword_targets();
    load_mixed_image();
    u_imem.mem[20][17:16] = 2'b00;
    u_imem.mem[40][17:16] = 2'b11;
    do_branch(32'h0000_0052);
    collect_stream(12, 1'b0);
    do_branch(32'h0000_00a2);
    collect_stream(12, 1'b0);
  endtask

  task automatic test_branch_in_flight();
    int waited;
    load_mixed_image();
    do_branch(32'h0000_0200);
    waited = 0;
    // Second branch lands while the first words are still on the bus
    while (!wb_req.cyc && waited < limit_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (!wb_req.cyc) begin
      report_timeout("first bus cycle");
    end
    do_branch(32'h0000_01c6);
    collect_stream(16, 1'b0);
  endtask

  task automatic test_backpressure_drain();
    int  waited;
    bit  idle;
    load_mixed_image();
    do_branch(32'h0000_0080);
    collect_stream(40, 1'b1);
    @(negedge clk);
    prefetch_en_i = 1'b0;
    instr_ready_i = 1'b1;
    waited        = 0;
    idle          = 1'b0;
    // Keep taking what arrives until the last response is in
    while (!idle && waited < limit_cycles) begin
      @(posedge clk);
      if (instr_valid_o) begin
        check_delivered();
      end
      idle = !busy_o;
      waited++;
    end
    if (!idle) begin
      report_timeout("busy_o to fall");
    end
    @(negedge clk);
    instr_ready_i = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      check_value("wb_req_o.cyc", wb_req.cyc, 32'd0);
    end
  endtask

  initial begin
    void'($urandom(71281));
    check_count    = 0;
    mismatch_count = 0;
    timeout_count  = 0;
    walk_addr      = '0;
    rst_n          = 1'b0;
    branch_i       = 1'b0;
    branch_addr_i  = '0;
    prefetch_en_i  = 1'b0;
    instr_ready_i  = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    test_idle_after_reset();
    test_aligned_wide();
    test_mixed_aligned();
    test_halfword_targets();
    test_branch_in_flight();
    test_backpressure_drain();

    $display("checks %0d, mismatches %0d, timeouts %0d",
             check_count, mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- fetch_unit.f
logic/fetch_pkg.sv
logic/fetch_align_buffer.sv
logic/fetch_wb_master.sv
logic/fetch_unit.sv
tb/tb_imem_model.sv
tb/tb_fetch_unit.sv
